// File: source/procPkg.sv
//**********************************************************
// Processor package: widths, memory depths, ISA encodings
// and the packed payloads carried between pipeline stages
//**********************************************************
package procPkg;

    localparam int DATA_W     = 16;
    localparam int REG_W      = 3;
    localparam int IMEM_DEPTH = 64;
    localparam int DMEM_DEPTH = 64;
    localparam int PC_W       = $clog2(IMEM_DEPTH);
    localparam int DADDR_W    = $clog2(DMEM_DEPTH);

    // Opcodes live in instruction bits 15:11
    localparam logic [4:0] OP_HALT  = 5'b00000;
    localparam logic [4:0] OP_NOP   = 5'b00001;
    localparam logic [4:0] OP_J     = 5'b00100;
    localparam logic [4:0] OP_ADDI  = 5'b01000;
    localparam logic [4:0] OP_SUBI  = 5'b01001;
    localparam logic [4:0] OP_XORI  = 5'b01010;
    localparam logic [4:0] OP_BEQZ  = 5'b01100;
    localparam logic [4:0] OP_BNEZ  = 5'b01101;
    localparam logic [4:0] OP_ST    = 5'b10000;
    localparam logic [4:0] OP_LD    = 5'b10001;
    localparam logic [4:0] OP_LBI   = 5'b11000;
    localparam logic [4:0] OP_RTYPE = 5'b11011;

    // R-format funct in bits 1:0
    localparam logic [1:0] FN_ADD = 2'd0;
    localparam logic [1:0] FN_SUB = 2'd1;
    localparam logic [1:0] FN_XOR = 2'd2;
    localparam logic [1:0] FN_AND = 2'd3;

    // Full NOP word; fetch stores instructions XORed with it so a
    // cleared IF/ID register reads back as a NOP and not a HALT
    localparam logic [DATA_W-1:0] NOP_WORD = {OP_NOP, 11'd0};

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_AND,
        ALU_PASSB
    } aluOpT;

    typedef struct packed {
        logic [PC_W-1:0]   pc;
        logic [DATA_W-1:0] instrEnc;
    } ifIdT;

    typedef struct packed {
        logic [PC_W-1:0]   pc;
        logic [DATA_W-1:0] opA;
        logic [DATA_W-1:0] opB;
        logic [DATA_W-1:0] imm;
        logic [REG_W-1:0]  rd;
        aluOpT             aluOp;
        logic              useImm;
        logic              memRead;
        logic              memWrite;
        logic              brZero;
        logic              brNonZero;
        logic              jump;
        logic              regWrite;
        logic              halt;
        logic              illegal;
    } idExT;

    typedef struct packed {
        logic [DATA_W-1:0] result;
        logic [DATA_W-1:0] storeData;
        logic [REG_W-1:0]  rd;
        logic              memRead;
        logic              memWrite;
        logic              regWrite;
        logic              halt;
        logic              illegal;
    } exMemT;

    typedef struct packed {
        logic [DATA_W-1:0] result;
        logic [REG_W-1:0]  rd;
        logic              regWrite;
        logic              halt;
        logic              illegal;
    } memWbT;

endpackage

// File: source/wbBus.sv
//**********************************************************
// Writeback bus from the memory/writeback stage back to
// the register file in decode
//**********************************************************
`timescale 1ns/1ns

interface wbBus;
    import procPkg::*;

    // Register write from a live instruction
    logic              en;
    logic [REG_W-1:0]  regIdx;
    logic [DATA_W-1:0] data;
    // HALT has reached writeback
    logic              halt;

    modport source (
        output en,
        output regIdx,
        output data,
        output halt
    );

    // Register file only needs the write port
    modport sink (
        input en,
        input regIdx,
        input data
    );

endinterface

// File: source/pipeReg.sv
//**********************************************************
// Generic pipeline stage register, any payload type;
// reset or flush loads an all-zero bubble
//**********************************************************
`timescale 1ns/1ns

module pipeReg #(
    parameter type payloadT = logic [7:0]
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    // All control bits clear in a bubble
    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

// File: source/fetch.sv
//**********************************************************
// Fetch stage: PC, loadable instruction memory, start and
// halt gating, and branch/jump redirect
//**********************************************************
`timescale 1ns/1ns

module fetch (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        progWe,
    input  logic [procPkg::PC_W-1:0]    progAddr,
    input  logic [procPkg::DATA_W-1:0]  progData,
    input  logic                        start,
    input  logic                        halted,
    input  logic                        redirect,
    input  logic [procPkg::PC_W-1:0]    redirectPc,
    output procPkg::ifIdT               ifId
);
    import procPkg::*;

    logic [DATA_W-1:0] imem [0:IMEM_DEPTH-1];
    logic [PC_W-1:0]   pc;
    logic              run;
    logic [DATA_W-1:0] fetchWord;

    assign run = start && !halted;

    // Program load port, only used before start
    always_ff @(posedge clk) begin
        if (progWe) begin
            imem[progAddr] <= progData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirectPc;
        end else if (run) begin
            pc <= pc + PC_W'(1);
        end
    end

    // Stopped fetch feeds NOPs
    assign fetchWord = run ? imem[pc] : NOP_WORD;

    always_comb begin
        ifId.pc       = pc;
        ifId.instrEnc = fetchWord ^ NOP_WORD;
    end

endmodule

// File: source/decode.sv
//**********************************************************
// Decode stage: control generation, immediates, and the
// register file with write-to-read bypass
//**********************************************************
`timescale 1ns/1ns

module decode (
    input  logic           clk,
    input  logic           rstN,
    input  procPkg::ifIdT  ifId,
    wbBus.sink             wb,
    output procPkg::idExT  idEx
);
    import procPkg::*;

    logic [DATA_W-1:0] regs [0:2**REG_W-1];
    logic [DATA_W-1:0] instr;
    logic [4:0]        opcode;
    logic [REG_W-1:0]  rs;
    logic [REG_W-1:0]  rMid;
    logic [REG_W-1:0]  rdR;
    logic [1:0]        funct;
    logic [DATA_W-1:0] imm5s;
    logic [DATA_W-1:0] imm5z;
    logic [DATA_W-1:0] imm8s;
    logic [DATA_W-1:0] disp11;
    logic [DATA_W-1:0] readA;
    logic [DATA_W-1:0] readB;

    // Undo the fetch-side NOP encoding
    assign instr  = ifId.instrEnc ^ NOP_WORD;
    assign opcode = instr[15:11];
    assign rs     = instr[10:8];
    assign rMid   = instr[7:5];
    assign rdR    = instr[4:2];
    assign funct  = instr[1:0];

    assign imm5s  = {{(DATA_W-5){instr[4]}}, instr[4:0]};
    assign imm5z  = {{(DATA_W-5){1'b0}}, instr[4:0]};
    assign imm8s  = {{(DATA_W-8){instr[7]}}, instr[7:0]};
    assign disp11 = {{(DATA_W-11){instr[10]}}, instr[10:0]};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 2**REG_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en) begin
            regs[wb.regIdx] <= wb.data;
        end
    end

    // Same-cycle writeback passes straight to the read
    assign readA = (wb.en && wb.regIdx == rs)   ? wb.data : regs[rs];
    assign readB = (wb.en && wb.regIdx == rMid) ? wb.data : regs[rMid];

    always_comb begin
        idEx       = '0;
        idEx.pc    = ifId.pc;
        idEx.opA   = readA;
        idEx.opB   = readB;
        idEx.rd    = rMid;
        idEx.aluOp = ALU_ADD;
        case (opcode)
            OP_HALT: idEx.halt = 1'b1;
            OP_NOP: ;
            OP_ADDI, OP_SUBI: begin
                idEx.aluOp    = (opcode == OP_SUBI) ? ALU_SUB : ALU_ADD;
                idEx.useImm   = 1'b1;
                idEx.imm      = imm5s;
                idEx.regWrite = 1'b1;
            end
            OP_XORI: begin
                idEx.aluOp    = ALU_XOR;
                idEx.useImm   = 1'b1;
                idEx.imm      = imm5z;
                idEx.regWrite = 1'b1;
            end
            OP_LBI: begin
                idEx.aluOp    = ALU_PASSB;
                idEx.useImm   = 1'b1;
                idEx.imm      = imm8s;
                idEx.rd       = rs;
                idEx.regWrite = 1'b1;
            end
            OP_LD, OP_ST: begin
                idEx.useImm   = 1'b1;
                idEx.imm      = imm5s;
                idEx.memRead  = (opcode == OP_LD);
                idEx.memWrite = (opcode == OP_ST);
                idEx.regWrite = (opcode == OP_LD);
            end
            OP_BEQZ: begin
                idEx.imm    = imm8s;
                idEx.brZero = 1'b1;
            end
            OP_BNEZ: begin
                idEx.imm       = imm8s;
                idEx.brNonZero = 1'b1;
            end
            OP_J: begin
                idEx.imm  = disp11;
                idEx.jump = 1'b1;
            end
            OP_RTYPE: begin
                idEx.rd       = rdR;
                idEx.regWrite = 1'b1;
                case (funct)
                    FN_ADD: idEx.aluOp = ALU_ADD;
                    FN_SUB: idEx.aluOp = ALU_SUB;
                    FN_XOR: idEx.aluOp = ALU_XOR;
                    FN_AND: idEx.aluOp = ALU_AND;
                endcase
            end
            // Unknown opcode, no side effects
            default: idEx.illegal = 1'b1;
        endcase
    end

endmodule

// File: source/execute.sv
//**********************************************************
// Execute stage: ALU, branch and jump resolution, and the
// redirect back to fetch
//**********************************************************
`timescale 1ns/1ns

module execute (
    input  procPkg::idExT               idEx,
    output procPkg::exMemT              exMem,
    output logic                        redirect,
    output logic [procPkg::PC_W-1:0]    redirectPc
);
    import procPkg::*;

    logic [DATA_W-1:0] aluB;
    logic [DATA_W-1:0] aluRes;
    logic              isZero;
    logic              brTaken;

    assign aluB = idEx.useImm ? idEx.imm : idEx.opB;

    always_comb begin
        case (idEx.aluOp)
            ALU_ADD:   aluRes = idEx.opA + aluB;
            ALU_SUB:   aluRes = idEx.opA - aluB;
            ALU_XOR:   aluRes = idEx.opA ^ aluB;
            ALU_AND:   aluRes = idEx.opA & aluB;
            // LBI
            ALU_PASSB: aluRes = aluB;
            default:   aluRes = '0;
        endcase
    end

    // Branch condition on the rs operand
    assign isZero  = (idEx.opA == '0);
    assign brTaken = (idEx.brZero && isZero) || (idEx.brNonZero && !isZero);

    assign redirect = brTaken || idEx.jump;

    // Target is PC + 1 + displacement, wraps within the imem
    assign redirectPc = idEx.pc + PC_W'(1) + idEx.imm[PC_W-1:0];

    always_comb begin
        exMem.result    = aluRes;
        // ST data comes from the rd field register
        exMem.storeData = idEx.opB;
        exMem.rd        = idEx.rd;
        exMem.memRead   = idEx.memRead;
        exMem.memWrite  = idEx.memWrite;
        exMem.regWrite  = idEx.regWrite;
        exMem.halt      = idEx.halt;
        exMem.illegal   = idEx.illegal;
    end

endmodule

// File: source/memWb.sv
//**********************************************************
// Memory and writeback: data memory, result select, the
// writeback bus, and sticky halted and error flags
//**********************************************************
`timescale 1ns/1ns

module memWb (
    input  logic            clk,
    input  logic            rstN,
    input  procPkg::exMemT  exMem,
    input  procPkg::memWbT  memWbQ,
    output procPkg::memWbT  memWbD,
    wbBus.source            wb,
    output logic            halted,
    output logic            err
);
    import procPkg::*;

    logic [DATA_W-1:0]  dmem [0:DMEM_DEPTH-1];
    logic [DADDR_W-1:0] addr;

    // Word address from the low ALU bits
    assign addr = exMem.result[DADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (exMem.memWrite) begin
            dmem[addr] <= exMem.storeData;
        end
    end

    always_comb begin
        memWbD.result   = exMem.memRead ? dmem[addr] : exMem.result;
        memWbD.rd       = exMem.rd;
        memWbD.regWrite = exMem.regWrite;
        memWbD.halt     = exMem.halt;
        memWbD.illegal  = exMem.illegal;
    end

    // Writeback from the registered stage
    assign wb.en     = memWbQ.regWrite;
    assign wb.regIdx = memWbQ.rd;
    assign wb.data   = memWbQ.result;
    assign wb.halt   = memWbQ.halt;

    // Both flags hold until reset
    always_ff @(posedge clk) begin
        if (!rstN) begin
            halted <= 1'b0;
            err    <= 1'b0;
        end else begin
            if (wb.halt) begin
                halted <= 1'b1;
            end
            if (memWbQ.illegal) begin
                err <= 1'b1;
            end
        end
    end

endmodule

// File: source/proc.sv
//**********************************************************
// Five-stage pipelined 16-bit processor top level
//**********************************************************
`timescale 1ns/1ns

module proc (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        progWe,
    input  logic [procPkg::PC_W-1:0]    progAddr,
    input  logic [procPkg::DATA_W-1:0]  progData,
    input  logic                        start,
    output logic                        wbValid,
    output logic [procPkg::REG_W-1:0]   wbReg,
    output logic [procPkg::DATA_W-1:0]  wbData,
    output logic                        halted,
    output logic                        err
);
    import procPkg::*;

    ifIdT            ifIdD, ifIdQ;
    idExT            idExD, idExQ;
    exMemT           exMemD, exMemQ;
    memWbT           memWbD, memWbQ;
    logic            redirect;
    logic [PC_W-1:0] redirectPc;

    wbBus wbIf ();

    fetch fetch0 (.clk(clk), .rstN(rstN), .progWe(progWe), .progAddr(progAddr),
        .progData(progData), .start(start), .halted(halted), .redirect(redirect),
        .redirectPc(redirectPc), .ifId(ifIdD));

    // Taken branch squashes the two younger instructions
    pipeReg #(.payloadT(ifIdT)) ifIdReg (.clk(clk), .rstN(rstN), .flush(redirect),
        .d(ifIdD), .q(ifIdQ));

    decode decode0 (.clk(clk), .rstN(rstN), .ifId(ifIdQ), .wb(wbIf.sink), .idEx(idExD));

    pipeReg #(.payloadT(idExT)) idExReg (.clk(clk), .rstN(rstN), .flush(redirect),
        .d(idExD), .q(idExQ));

    execute exec0 (.idEx(idExQ), .exMem(exMemD), .redirect(redirect),
        .redirectPc(redirectPc));

    pipeReg #(.payloadT(exMemT)) exMemReg (.clk(clk), .rstN(rstN), .flush(1'b0),
        .d(exMemD), .q(exMemQ));

    memWb memWb0 (.clk(clk), .rstN(rstN), .exMem(exMemQ), .memWbQ(memWbQ),
        .memWbD(memWbD), .wb(wbIf.source), .halted(halted), .err(err));

    pipeReg #(.payloadT(memWbT)) memWbReg (.clk(clk), .rstN(rstN), .flush(1'b0),
        .d(memWbD), .q(memWbQ));

    // Observation port mirrors the writeback bus
    assign wbValid = wbIf.en;
    assign wbReg   = wbIf.regIdx;
    assign wbData  = wbIf.data;

endmodule

// File: testbench/procTb.sv
//**********************************************************
// Testbench for the pipelined processor that loads each
// program from a table, runs it and checks the writebacks
//**********************************************************
`timescale 1ns/1ns

module procTb;
    import procPkg::*;

    localparam int NUM_CASES  = 5;
    localparam int PROG_WORDS = 60;
    localparam int WB_ROWS    = 30;
    localparam int RUN_LIMIT  = 200;
    localparam int SEED       = 32'hd053a6ac;

    localparam logic [DATA_W-1:0] NOP_INS  = {OP_NOP, 11'd0};
    localparam logic [DATA_W-1:0] HALT_INS = {OP_HALT, 11'd0};
    // Opcode 11111 is not in the ISA
    localparam logic [DATA_W-1:0] BAD_INS  = 16'hF800;

    logic                clk;
    logic                rstN;
    logic                progWe;
    logic [PC_W-1:0]     progAddr;
    logic [DATA_W-1:0]   progData;
    logic                start;
    logic                wbValid;
    logic [REG_W-1:0]    wbReg;
    logic [DATA_W-1:0]   wbData;
    logic                halted;
    logic                err;

    // Programs stored back to back
    logic [DATA_W-1:0]   progTable [PROG_WORDS];
    // Expected writebacks as {reg, data}
    logic [18:0]         expWb [WB_ROWS];
    int                  progLen [NUM_CASES];
    int                  expCount [NUM_CASES];
    int                  expErr [NUM_CASES];
    int                  curCase;

    proc uut (.clk(clk), .rstN(rstN), .progWe(progWe), .progAddr(progAddr),
        .progData(progData), .start(start), .wbValid(wbValid), .wbReg(wbReg),
        .wbData(wbData), .halted(halted), .err(err));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Instruction encoders for the I1, R, I2 and J formats
    function automatic logic [15:0] encI1(logic [4:0] op, int rs, int rd, int imm);
        return {op, rs[2:0], rd[2:0], imm[4:0]};
    endfunction

    function automatic logic [15:0] encR(int rs, int rt, int rd, logic [1:0] fn);
        return {OP_RTYPE, rs[2:0], rt[2:0], rd[2:0], fn};
    endfunction

    function automatic logic [15:0] encI2(logic [4:0] op, int rs, int imm);
        return {op, rs[2:0], imm[7:0]};
    endfunction

    function automatic logic [15:0] encJ(int disp);
        return {OP_J, disp[10:0]};
    endfunction

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s in case %0d: got 0x%0h, expected 0x%0h", name, curCase, got, exp);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic fillTables();
        progTable = '{
            // Arithmetic and R-format
            encI2(OP_LBI, 1, 7), encI2(OP_LBI, 2, -3), encI2(OP_LBI, 3, 'h5A),
            NOP_INS, encI1(OP_ADDI, 1, 4, 5), encI1(OP_ADDI, 2, 5, -4),
            encI1(OP_SUBI, 3, 6, -6), encI1(OP_XORI, 2, 7, 'h13), encR(1, 2, 5, FN_SUB),
            encR(3, 2, 6, FN_XOR), encR(3, 4, 7, FN_AND), encR(4, 2, 1, FN_ADD),
            HALT_INS,
            // Stores then loads
            encI2(OP_LBI, 3, 'h20), encI2(OP_LBI, 1, 'h12), encI2(OP_LBI, 2, -100),
            NOP_INS, NOP_INS, encI1(OP_ST, 3, 1, 3),
            encI1(OP_ST, 3, 2, -5), encI1(OP_LD, 3, 4, 3), encI1(OP_LD, 3, 5, -5),
            HALT_INS,
            // Taken and not-taken branches with a bad word in a shadow
            encI2(OP_LBI, 1, 0), encI2(OP_LBI, 2, 5), NOP_INS,
            NOP_INS, encI2(OP_BEQZ, 1, 2), encI2(OP_LBI, 3, 1),
            BAD_INS, encI2(OP_BNEZ, 2, 2), encI2(OP_LBI, 3, 2),
            encI2(OP_LBI, 4, 2), encI2(OP_LBI, 5, 2), encI2(OP_BEQZ, 2, 5),
            encI2(OP_LBI, 6, 'h33), encI2(OP_BNEZ, 1, -10), encI2(OP_LBI, 7, -1),
            HALT_INS,
            // Jumps both ways around a counted loop
            encI2(OP_LBI, 1, 3), encI2(OP_LBI, 2, 'h10), encJ(4),
            encI2(OP_LBI, 3, 1), encI2(OP_LBI, 3, 2), encI2(OP_LBI, 4, 'h22),
            encJ(8), encI1(OP_ADDI, 1, 1, -1), NOP_INS,
            NOP_INS, NOP_INS, encI2(OP_BNEZ, 1, -5),
            encJ(-8), encI2(OP_LBI, 5, 1), encI2(OP_LBI, 5, 2),
            encI2(OP_LBI, 6, 'h44), HALT_INS,
            // Illegal word retires
            encI2(OP_LBI, 1, 1), BAD_INS, encI2(OP_LBI, 2, 2), HALT_INS
        };
        expWb = '{
            {3'd1, 16'h0007}, {3'd2, 16'hFFFD}, {3'd3, 16'h005A}, {3'd4, 16'h000C},
            {3'd5, 16'hFFF9}, {3'd6, 16'h0060}, {3'd7, 16'hFFEE}, {3'd5, 16'h000A},
            {3'd6, 16'hFFA7}, {3'd7, 16'h0008}, {3'd1, 16'h0009},
            {3'd3, 16'h0020}, {3'd1, 16'h0012}, {3'd2, 16'hFF9C}, {3'd4, 16'h0012},
            {3'd5, 16'hFF9C},
            {3'd1, 16'h0000}, {3'd2, 16'h0005}, {3'd5, 16'h0002}, {3'd6, 16'h0033},
            {3'd7, 16'hFFFF},
            {3'd1, 16'h0003}, {3'd2, 16'h0010}, {3'd1, 16'h0002}, {3'd1, 16'h0001},
            {3'd1, 16'h0000}, {3'd4, 16'h0022}, {3'd6, 16'h0044},
            {3'd1, 16'h0001}, {3'd2, 16'h0002}
        };
        progLen  = '{13, 10, 16, 17, 4};
        expCount = '{11, 5, 5, 7, 2};
        expErr   = '{0, 0, 0, 0, 1};
    endtask

    task automatic resetDut();
        @(posedge clk);
        rstN  <= 1'b0;
        start <= 1'b0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
    endtask

    // Four NOPs follow the program for the words fetched behind HALT
    // Remaining words load r7 with their own address
    task automatic loadProgram(input int c, input int base);
        for (int a = 0; a < IMEM_DEPTH; a++) begin
            @(posedge clk);
            progWe   <= 1'b1;
            progAddr <= PC_W'(a);
            if (a < progLen[c]) begin
                progData <= progTable[base + a];
            end else if (a < progLen[c] + 4) begin
                progData <= NOP_INS;
            end else begin
                progData <= encI2(OP_LBI, 7, a);
            end
        end
        @(posedge clk);
        progWe <= 1'b0;
    endtask

    task automatic runCase(input int c, input int progBase, input int wbBase);
        logic [18:0] gotWb [$];
        int          idle;
        int          cycles;
        resetDut();
        loadProgram(c, progBase);
        idle = 1 + int'($urandom % 4);
        repeat (idle) @(posedge clk);
        start <= 1'b1;
        cycles = 0;
        while (!halted && cycles < RUN_LIMIT) begin
            @(negedge clk);
            if (wbValid) begin
                gotWb.push_back({wbReg, wbData});
            end
            cycles++;
        end
        if (!halted) begin
            $display("Timeout in case %0d: halted never rose within %0d cycles", c, RUN_LIMIT);
            $display("Simulation FAILED");
            $fatal(1);
        end
        // Nothing more may retire once halted
        repeat (20) begin
            @(negedge clk);
            checkEq("halted", 32'(halted), 32'd1);
            if (wbValid) begin
                gotWb.push_back({wbReg, wbData});
            end
        end
        checkEq("wbCount", 32'(gotWb.size()), 32'(expCount[c]));
        for (int k = 0; k < gotWb.size(); k++) begin
            checkEq("wbReg", 32'(gotWb[k][18:16]), 32'(expWb[wbBase + k][18:16]));
            checkEq("wbData", 32'(gotWb[k][15:0]), 32'(expWb[wbBase + k][15:0]));
        end
        checkEq("err", 32'(err), 32'(expErr[c]));
    endtask

    initial begin
        int progBase;
        int wbBase;
        rstN     <= 1'b0;
        progWe   <= 1'b0;
        progAddr <= '0;
        progData <= '0;
        start    <= 1'b0;
        void'($urandom(SEED));
        fillTables();
        progBase = 0;
        wbBase   = 0;
        for (int c = 0; c < NUM_CASES; c++) begin
            curCase = c;
            runCase(c, progBase, wbBase);
            progBase += progLen[c];
            wbBase   += expCount[c];
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: proc.f
source/procPkg.sv
source/wbBus.sv
source/pipeReg.sv
source/fetch.sv
source/decode.sv
source/execute.sv
source/memWb.sv
source/proc.sv
testbench/procTb.sv

// File: Makefile
# Verilator build and run for the pipelined processor
VERILATOR ?= verilator
TB_TOP    ?= procTb
RTL_TOP   ?= proc
FILELIST  ?= proc.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	grep -q "^Simulation PASSED$$" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
